// ==== verilog.f ====
+incdir+rtl
rtl/insn_pkg.sv
rtl/rob_pkg.sv
rtl/insn_decode.sv
rtl/branch_execute.sv
rtl/rob_stomp.sv
rtl/stomp_core.sv
test/stomp_core_chk.sv
test/stomp_core_monitor.sv
test/stomp_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the branch recovery testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f verilog.f --top-module stomp_core_tb -o sim_stomp \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_stomp > sim.log 2>&1 || echo "simulator returned a failing status" >> sim.log
cat sim.log
! grep -q "Simulation failed" sim.log && grep -q "Simulation completed successfully" sim.log \
	&& { echo "PASS"; exit 0; } || { echo "FAIL"; exit 1; }

// ==== test/stomp_core_tb.sv ====
// testbench for the branch recovery core with program-ordered random stimulus
`timescale 1ns/1ps
`include "stomp_defines.svh"

module stomp_core_tb;

	localparam int NUM_PKTS = 300;
	// 200 ns per packet plus 2 us of margin
	localparam int LIMIT_NS = 200 * NUM_PKTS + 2000;

	logic                  clk;
	logic                  rst;
	insn_pkg::fetch_pkt_t  in_pkt;
	logic                  in_valid;
	logic                  in_ready;
	rob_pkg::retire_t      retire;
	logic                  out_valid;
	logic                  out_ready;
	logic                  redirect_valid;
	logic [`PC_W-1:0]      redirect_pc;
	int                    phase;
	int                    errors;
	int                    retired;
	int                    redirects;
	logic                  idle;
	int                    sent;
	logic [31:0]           rng;
	logic [31:0]           ready_rng;

	stomp_core DUT (
		.clk            (clk),
		.rst            (rst),
		.in_pkt         (in_pkt),
		.in_valid       (in_valid),
		.in_ready       (in_ready),
		.retire         (retire),
		.out_valid      (out_valid),
		.out_ready      (out_ready),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc)
	);

	stomp_core_monitor u_mon (
		.clk            (clk),
		.rst            (rst),
		.phase          (phase),
		.in_pkt         (in_pkt),
		.in_valid       (in_valid),
		.in_ready       (in_ready),
		.retire         (retire),
		.out_valid      (out_valid),
		.out_ready      (out_ready),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.errors         (errors),
		.retired        (retired),
		.redirects      (redirects),
		.idle           (idle)
	);

	// ========================================
	// helpers
	// ========================================

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic insn_pkg::fetch_pkt_t make_alu(input logic [`PC_W-1:0] pc,
	                                                 input logic [`STREAM_W-1:0] stream,
	                                                 input logic [`IMM_W-1:0] imm);
		insn_pkg::fetch_pkt_t p;
		p.pc                   = pc;
		p.stream               = stream;
		p.pred_taken           = 1'b0;
		p.word.alu_fmt.opcode  = insn_pkg::OP_ALU;
		p.word.alu_fmt.pad     = '0;
		p.word.alu_fmt.imm     = imm;
		return p;
	endfunction

	function automatic insn_pkg::fetch_pkt_t make_br(input logic [`PC_W-1:0] pc,
	                                                input logic [`STREAM_W-1:0] stream,
	                                                input logic pred,
	                                                input logic [`STREAM_W-1:0] tstream,
	                                                input logic [3:0] a,
	                                                input logic [3:0] b,
	                                                input logic [16:0] off);
		insn_pkg::fetch_pkt_t p;
		p.pc                       = pc;
		p.stream                   = stream;
		p.pred_taken               = pred;
		p.word.br_fmt.opcode       = insn_pkg::OP_BR;
		p.word.br_fmt.target_stream = tstream;
		p.word.br_fmt.cmp_a        = a;
		p.word.br_fmt.cmp_b        = b;
		p.word.br_fmt.target_off   = off;
		return p;
	endfunction

	// presents one packet from a rising edge and returns on the edge that takes it
	task automatic send_pkt(input insn_pkg::fetch_pkt_t p);
		logic done;
		in_pkt   <= p;
		in_valid <= 1'b1;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			done = in_ready;
			@(posedge clk);
		end
		in_valid <= 1'b0;
		sent++;
	endtask

	// ========================================
	// clock, reset, watchdog
	// ========================================

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		#(LIMIT_NS);
		$display("watchdog expired before every expected retire was seen");
		$display("Simulation failed");
		$finish;
	end

	// retire back-pressure stays steady early and turns random later on
	always @(posedge clk) begin
		ready_rng = xorshift(ready_rng);
		if (rst || phase < 2)
			out_ready <= 1'b1;
		else
			out_ready <= ready_rng[4:0] > 5'd10;
	end

	// ========================================
	// program-ordered stimulus
	// ========================================

	initial begin
		logic [`STREAM_W-1:0] cur;
		logic [`STREAM_W-1:0] tstream;
		logic [`STREAM_W-1:0] wrong;
		logic [`PC_W-1:0]     pc;
		logic [`PC_W-1:0]     tgt;
		logic [`PC_W-1:0]     wpc;
		logic [3:0]           a;
		logic [3:0]           b;
		logic [16:0]          off;
		logic                 is_br;
		logic                 taken;
		logic                 miss;
		int                   n_wrong;
		rst       = 1'b1;
		in_valid  = 1'b0;
		in_pkt    = '0;
		out_ready = 1'b1;
		phase     = 0;
		sent      = 0;
		rng       = 32'd56057;
		ready_rng = xorshift(32'd56057 ^ 32'h9e3779b9);
		cur       = '0;
		pc        = 16'h1000;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		while (sent < NUM_PKTS) begin
			phase <= sent < 40 ? 0 : sent < 90 ? 1 : sent < 160 ? 2 : 3;
			rng = xorshift(rng);
			is_br = (sent >= 40) && (rng[3:0] < (sent >= 90 && sent < 160 ? 4'd9 : 4'd5));
			if (!is_br) begin
				send_pkt(make_alu(pc, cur, rng[31:16]));
				pc = pc + 16'd4;
			end else begin
				taken   = rng[8];
				a       = rng[7:4];
				// a not-taken compare field differs by one to eight
				b       = taken ? a : a + 4'd1 + {1'b0, rng[11:9]};
				// mostly right in the predicted phase and often wrong afterwards
				miss    = sent < 90 ? 1'b0 : sent < 160 ? (rng[12] | rng[13]) : (rng[12] & rng[13]);
				tstream = cur + 3'd1 + {1'b0, rng[15:14]};
				off     = {rng[28:16], 4'b0};
				tgt     = pc + off[`PC_W-1:0];
				send_pkt(make_br(pc, cur, taken ^ miss, tstream, a, b, off));
				if (miss) begin
					// fetch followed the prediction down the path that loses
					wrong   = taken ? cur : tstream;
					wpc     = taken ? pc + 16'd4 : tgt;
					n_wrong = 1 + int'(rng[30:29]) % 3;
					for (int i = 0; i < n_wrong && sent < NUM_PKTS; i++) begin
						rng = xorshift(rng);
						if (rng[0])
							send_pkt(make_br(wpc, wrong, rng[1], wrong + 3'd1 + {1'b0, rng[3:2]},
								rng[7:4], rng[11:8], {rng[24:12], 4'b0}));
						else
							send_pkt(make_alu(wpc, wrong, rng[31:16]));
						wpc = wpc + 16'd4;
					end
				end
				cur = taken ? tstream : cur;
				pc  = taken ? tgt : pc + 16'd4;
			end
			// an occasional bubble on the fetch side
			if (rng[19:17] == 3'd0)
				@(posedge clk);
		end
		do
			@(negedge clk);
		while (!idle);
		// stray retires or redirects would still show up here
		repeat (20) @(posedge clk);
		$display("sent=%0d retired=%0d redirects=%0d errors=%0d", sent, retired, redirects, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== test/stomp_core_monitor.sv ====
// scoreboard that predicts retires and redirects from accepted packets and compares
`timescale 1ns/1ps
`include "stomp_defines.svh"

module stomp_core_monitor (
	input  logic                  clk,
	input  logic                  rst,
	input  int                    phase,
	input  insn_pkg::fetch_pkt_t  in_pkt,
	input  logic                  in_valid,
	input  logic                  in_ready,
	input  rob_pkg::retire_t      retire,
	input  logic                  out_valid,
	input  logic                  out_ready,
	input  logic                  redirect_valid,
	input  logic [`PC_W-1:0]      redirect_pc,
	output int                    errors,
	output int                    retired,
	output int                    redirects,
	output logic                  idle
);

	// what one accepted packet means for the program
	typedef struct packed {
		logic                  keep;
		logic                  redirect;
		logic [`PC_W-1:0]      redir_pc;
		logic [`STREAM_W-1:0]  kept_next;
		rob_pkg::retire_t      ret;
	} ref_t;

	rob_pkg::retire_t      exp_ret_q[$];
	int                    exp_ret_phase_q[$];
	logic [`PC_W-1:0]      exp_redir_q[$];
	int                    exp_redir_phase_q[$];
	logic [`STREAM_W-1:0]  kept;

	// ========================================
	// reference model
	// ========================================

	// only the kept stream survives, and each surviving branch picks the next kept stream
	function automatic ref_t predict(input insn_pkg::fetch_pkt_t p,
	                                 input logic [`STREAM_W-1:0] cur_kept);
		ref_t             r;
		logic             br;
		logic             taken;
		logic [`PC_W-1:0] tgt;
		br    = p.word.br_fmt.opcode == insn_pkg::OP_BR;
		taken = br && (p.word.br_fmt.cmp_a == p.word.br_fmt.cmp_b);
		tgt   = p.pc + p.word.br_fmt.target_off[`PC_W-1:0];
		r.keep       = p.stream == cur_kept;
		r.redirect   = r.keep && br && (taken != p.pred_taken);
		r.redir_pc   = taken ? tgt : p.pc + `PC_W'(4);
		r.kept_next  = cur_kept;
		if (r.keep && br)
			r.kept_next = taken ? p.word.br_fmt.target_stream : p.stream;
		r.ret.pc     = p.pc;
		r.ret.stream = p.stream;
		r.ret.is_br  = br;
		r.ret.taken  = taken;
		// branches report their target, ALU ops pc plus the immediate
		r.ret.result = br ? tgt : p.pc + p.word.alu_fmt.imm;
		return r;
	endfunction

	function automatic string phase_name(input int ph);
		case (ph)
			0:       return "alu_only";
			1:       return "predicted_branches";
			2:       return "mispredicts";
			default: return "random_stalls";
		endcase
	endfunction

	// ========================================
	// comparing process
	// ========================================

	always @(posedge clk) begin
		ref_t r;
		int   ph;
		if (rst) begin
			kept      = '0;
			errors    = 0;
			retired   = 0;
			redirects = 0;
			exp_ret_q.delete();
			exp_ret_phase_q.delete();
			exp_redir_q.delete();
			exp_redir_phase_q.delete();
		end else begin
			if (in_valid && in_ready) begin
				r = predict(in_pkt, kept);
				kept = r.kept_next;
				if (r.keep) begin
					exp_ret_q.push_back(r.ret);
					exp_ret_phase_q.push_back(phase);
				end
				if (r.redirect) begin
					exp_redir_q.push_back(r.redir_pc);
					exp_redir_phase_q.push_back(phase);
				end
			end
			if (out_valid && out_ready) begin
				retired++;
				if (exp_ret_q.size() == 0) begin
					errors++;
					$display("retire of pc %h seen with no instruction left to retire", retire.pc);
				end else begin
					ph = exp_ret_phase_q.pop_front();
					if (retire !== exp_ret_q[0]) begin
						errors++;
						$display("[ERROR] %s retire: expected %h actual %h",
							phase_name(ph), exp_ret_q[0], retire);
					end
					void'(exp_ret_q.pop_front());
				end
			end
			if (redirect_valid) begin
				redirects++;
				if (exp_redir_q.size() == 0) begin
					errors++;
					$display("redirect to %h raised with no mispredict outstanding", redirect_pc);
				end else begin
					ph = exp_redir_phase_q.pop_front();
					if (redirect_pc !== exp_redir_q[0]) begin
						errors++;
						$display("[ERROR] %s redirect: expected %h actual %h",
							phase_name(ph), exp_redir_q[0], redirect_pc);
					end
					void'(exp_redir_q.pop_front());
				end
			end
		end
		idle = (exp_ret_q.size() == 0) && (exp_redir_q.size() == 0);
	end

endmodule

// ==== test/stomp_core_chk.sv ====
// protocol assertions on the handshakes, redirect pulse and reset state of the core
`timescale 1ns/1ps
`include "stomp_defines.svh"

module stomp_core_chk (
	input logic                  clk,
	input logic                  rst,
	input rob_pkg::rob_entry_t   alloc_entry,
	input logic                  alloc_valid,
	input logic                  alloc_ready,
	input rob_pkg::retire_t      retire,
	input logic                  out_valid,
	input logic                  out_ready,
	input logic                  redirect_valid,
	input logic                  dec_valid,
	input logic                  resolve_valid
);

	// ========================================
	// handshake hold rules
	// ========================================

	// an op held back by a full buffer keeps its stream, sequence number and payload
	assert property (@(posedge clk) disable iff (rst)
		alloc_valid && !alloc_ready |=> alloc_valid && $stable(alloc_entry))
		else $error("allocation request changed or dropped while the buffer was full");

	// the retire port may not withdraw or change its head entry
	assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(retire))
		else $error("retire entry changed or dropped while stalled");

	// ========================================
	// redirect and reset
	// ========================================

	// each mispredict gives a single cycle pulse
	assert property (@(posedge clk) disable iff (rst)
		redirect_valid |=> !redirect_valid)
		else $error("redirect held high for two cycles");

	// the cycle after any reset cycle starts with every stage empty
	assert property (@(posedge clk)
		rst |=> !dec_valid && !alloc_valid && !resolve_valid && !redirect_valid && !out_valid)
		else $error("a valid signal was high right after reset");

endmodule

bind stomp_core stomp_core_chk u_chk (
	.clk            (clk),
	.rst            (rst),
	.alloc_entry    (alloc_entry),
	.alloc_valid    (alloc_valid),
	.alloc_ready    (alloc_ready),
	.retire         (retire),
	.out_valid      (out_valid),
	.out_ready      (out_ready),
	.redirect_valid (redirect_valid),
	.dec_valid      (dec_valid),
	.resolve_valid  (resolve_valid)
);

// ==== rtl/stomp_core.sv ====
// branch recovery back end joining decode, execute and the reorder buffer
`timescale 1ns/1ps
`include "stomp_defines.svh"

module stomp_core (
	input  logic                  clk,
	input  logic                  rst,
	input  insn_pkg::fetch_pkt_t  in_pkt,
	input  logic                  in_valid,
	output logic                  in_ready,
	output rob_pkg::retire_t      retire,
	output logic                  out_valid,
	input  logic                  out_ready,
	output logic                  redirect_valid,
	output logic [`PC_W-1:0]      redirect_pc
);

	// decode to execute
	insn_pkg::dec_op_t   dec_op;
	logic                dec_valid;
	logic                dec_ready;

	// execute to reorder buffer
	rob_pkg::rob_entry_t alloc_entry;
	logic                alloc_valid;
	logic                alloc_ready;
	rob_pkg::rob_tag_t   alloc_tag;
	rob_pkg::resolve_t   resolve;
	logic                resolve_valid;

	insn_decode u_decode (
		.clk       (clk),
		.rst       (rst),
		.in_pkt    (in_pkt),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.dec_op    (dec_op),
		.dec_valid (dec_valid),
		.dec_ready (dec_ready)
	);

	branch_execute u_execute (
		.clk            (clk),
		.rst            (rst),
		.dec_op         (dec_op),
		.dec_valid      (dec_valid),
		.dec_ready      (dec_ready),
		.alloc_entry    (alloc_entry),
		.alloc_valid    (alloc_valid),
		.alloc_ready    (alloc_ready),
		.alloc_tag      (alloc_tag),
		.resolve        (resolve),
		.resolve_valid  (resolve_valid),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc)
	);

	rob_stomp u_rob (
		.clk           (clk),
		.rst           (rst),
		.alloc_entry   (alloc_entry),
		.alloc_valid   (alloc_valid),
		.alloc_ready   (alloc_ready),
		.alloc_tag     (alloc_tag),
		.resolve       (resolve),
		.resolve_valid (resolve_valid),
		.retire        (retire),
		.out_valid     (out_valid),
		.out_ready     (out_ready)
	);

endmodule

// ==== rtl/rob_stomp.sv ====
// reorder buffer that stomps wrong-stream entries and retires in program order
`timescale 1ns/1ps
`include "stomp_defines.svh"

module rob_stomp (
	input  logic                 clk,
	input  logic                 rst,
	input  rob_pkg::rob_entry_t  alloc_entry,
	input  logic                 alloc_valid,
	output logic                 alloc_ready,
	output rob_pkg::rob_tag_t    alloc_tag,
	input  rob_pkg::resolve_t    resolve,
	input  logic                 resolve_valid,
	output rob_pkg::retire_t     retire,
	output logic                 out_valid,
	input  logic                 out_ready
);

	rob_pkg::rob_entry_t mem [`ROB_DEPTH];

	rob_pkg::rob_tag_t   head_q;
	rob_pkg::rob_tag_t   tail_q;
	logic [`ROB_TAG_W:0] count_q;
	rob_pkg::rob_entry_t head_e;
	logic [`SN_W-1:0]    br_sn;
	logic                head_live;
	logic                head_dead;
	logic                head_busy;
	logic                alloc_fire;
	logic                free;

	// true when sequence number a was issued after b, modulo wrap
	function automatic logic is_younger(input logic [`SN_W-1:0] a, input logic [`SN_W-1:0] b);
		logic [`SN_W-1:0] diff;
		diff = a - b;
		return (diff != '0) && !diff[`SN_W-1];
	endfunction

	// ========================================
	// allocation side
	// ========================================

	assign alloc_ready = count_q != (`ROB_TAG_W+1)'(`ROB_DEPTH);
	assign alloc_tag   = tail_q;
	assign alloc_fire  = alloc_valid && alloc_ready;

	// ========================================
	// retire side
	// ========================================

	assign head_e    = mem[head_q];
	assign head_live = head_e.valid && !head_e.stomped;
	assign head_dead = head_e.valid && head_e.stomped;

	// a branch at the head waits while its own resolve is in flight
	assign head_busy = resolve_valid && (resolve.tag == head_q);
	assign out_valid = head_live && !head_busy;

	// stomped heads leave silently, live ones only on the handshake
	assign free = head_dead || (out_valid && out_ready);

	assign retire.pc     = head_e.pc;
	assign retire.stream = head_e.stream;
	assign retire.is_br  = head_e.is_br;
	assign retire.taken  = head_e.taken;
	assign retire.result = head_e.result;

	// age reference for the stomp sweep
	assign br_sn = mem[resolve.tag].sn;

	// ========================================
	// pointers and occupancy
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
		end else begin
			if (alloc_fire)
				tail_q <= tail_q + 1'b1;
			if (free)
				head_q <= head_q + 1'b1;
			if (alloc_fire && !free)
				count_q <= count_q + 1'b1;
			else if (free && !alloc_fire)
				count_q <= count_q - 1'b1;
		end
	end

	// ========================================
	// entry storage
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `ROB_DEPTH; i++) begin
				mem[i].valid   <= 1'b0;
				mem[i].stomped <= 1'b0;
			end
		end else begin
			if (resolve_valid) begin
				// the stored prediction flips into the outcome on a miss
				mem[resolve.tag].taken <= mem[resolve.tag].taken ^ resolve.miss;
				// everything younger that is not on the kept stream is dead
				for (int i = 0; i < `ROB_DEPTH; i++) begin
					if (mem[i].valid && is_younger(mem[i].sn, br_sn) &&
					    mem[i].stream != resolve.kept_stream)
						mem[i].stomped <= 1'b1;
				end
			end
			if (free)
				mem[head_q].valid <= 1'b0;
			// the tail slot is empty so the new entry never meets the sweep
			if (alloc_fire)
				mem[tail_q] <= alloc_entry;
		end
	end

endmodule

// ==== rtl/branch_execute.sv ====
// execute stage with stream filter, ALU, allocation and branch resolution
`timescale 1ns/1ps
`include "stomp_defines.svh"

module branch_execute (
	input  logic                  clk,
	input  logic                  rst,
	input  insn_pkg::dec_op_t     dec_op,
	input  logic                  dec_valid,
	output logic                  dec_ready,
	output rob_pkg::rob_entry_t   alloc_entry,
	output logic                  alloc_valid,
	input  logic                  alloc_ready,
	input  rob_pkg::rob_tag_t     alloc_tag,
	output rob_pkg::resolve_t     resolve,
	output logic                  resolve_valid,
	output logic                  redirect_valid,
	output logic [`PC_W-1:0]      redirect_pc
);

	logic [`STREAM_W-1:0] kept_q;
	logic [`STREAM_W-1:0] kept_nxt;
	logic [`STREAM_W-1:0] kept_eff;
	logic [`SN_W-1:0]     sn_q;
	logic                 pend_valid;
	rob_pkg::rob_tag_t    pend_tag;
	insn_pkg::dec_op_t    pend_op;
	logic                 br_taken;
	logic                 br_miss;
	logic                 stream_ok;
	logic                 alloc_fire;

	// ========================================
	// resolution of the pending branch
	// ========================================

	// the branch allocated last cycle is evaluated now
	assign br_taken = pend_op.cmp_a == pend_op.cmp_b;
	assign br_miss  = br_taken != pend_op.pred_taken;

	// a taken branch moves execution to its target stream
	assign kept_nxt = br_taken ? pend_op.target_stream : pend_op.stream;

	assign resolve.tag         = pend_tag;
	assign resolve.kept_stream = kept_nxt;
	assign resolve.miss        = br_miss;
	assign resolve_valid       = pend_valid;

	assign redirect_valid = pend_valid && br_miss;
	assign redirect_pc    = br_taken ? pend_op.target_pc : pend_op.pc + `PC_W'(4);

	// ========================================
	// stream filter and allocation
	// ========================================

	// during a resolve the new kept stream already filters, old path ops die here
	assign kept_eff  = pend_valid ? kept_nxt : kept_q;
	assign stream_ok = dec_op.stream == kept_eff;

	// ops from another stream are swallowed without waiting on the buffer
	assign alloc_valid = dec_valid && stream_ok;
	assign dec_ready   = !stream_ok || alloc_ready;
	assign alloc_fire  = alloc_valid && alloc_ready;

	// branches carry the prediction in taken and their target in result
	always_comb begin
		alloc_entry.valid   = 1'b1;
		alloc_entry.stomped = 1'b0;
		alloc_entry.sn      = sn_q;
		alloc_entry.pc      = dec_op.pc;
		alloc_entry.stream  = dec_op.stream;
		alloc_entry.is_br   = dec_op.is_br;
		alloc_entry.taken   = dec_op.is_br && dec_op.pred_taken;
		alloc_entry.result  = dec_op.is_br ? dec_op.target_pc : dec_op.pc + dec_op.imm16;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			kept_q     <= '0;
			sn_q       <= '0;
			pend_valid <= 1'b0;
		end else begin
			if (pend_valid)
				kept_q <= kept_nxt;
			if (alloc_fire)
				sn_q <= sn_q + 1'b1;
			// resolve is a single cycle pulse, a following branch may refill it
			pend_valid <= alloc_fire && dec_op.is_br;
		end
	end

	// the tag lets the following op allocate before this branch resolves
	always_ff @(posedge clk) begin
		if (alloc_fire && dec_op.is_br) begin
			pend_tag <= alloc_tag;
			pend_op  <= dec_op;
		end
	end

endmodule

// ==== rtl/insn_decode.sv ====
// decode stage that splits the fetched word into a registered decoded op
`timescale 1ns/1ps
`include "stomp_defines.svh"

module insn_decode (
	input  logic                  clk,
	input  logic                  rst,
	input  insn_pkg::fetch_pkt_t  in_pkt,
	input  logic                  in_valid,
	output logic                  in_ready,
	output insn_pkg::dec_op_t     dec_op,
	output logic                  dec_valid,
	input  logic                  dec_ready
);

	insn_pkg::dec_op_t nxt_op;

	// the register can take a new packet when it is empty or being drained
	assign in_ready = !dec_valid || dec_ready;

	// both views of the word are read here and the opcode picks which one counts
	always_comb begin
		nxt_op.pc            = in_pkt.pc;
		nxt_op.stream        = in_pkt.stream;
		nxt_op.pred_taken    = in_pkt.pred_taken;
		nxt_op.is_br         = in_pkt.word.br_fmt.opcode == insn_pkg::OP_BR;
		nxt_op.imm16         = in_pkt.word.alu_fmt.imm;
		nxt_op.target_stream = in_pkt.word.br_fmt.target_stream;
		nxt_op.cmp_a         = in_pkt.word.br_fmt.cmp_a;
		nxt_op.cmp_b         = in_pkt.word.br_fmt.cmp_b;
		// the 17 bit offset wraps into the pc space
		nxt_op.target_pc     = in_pkt.pc + in_pkt.word.br_fmt.target_off[`PC_W-1:0];
	end

	// the register is full from acceptance until execute drains it
	always_ff @(posedge clk) begin
		if (rst)
			dec_valid <= 1'b0;
		else if (in_valid && in_ready)
			dec_valid <= 1'b1;
		else if (dec_ready)
			dec_valid <= 1'b0;
	end

	// payload only moves on acceptance so it holds while stalled
	always_ff @(posedge clk) begin
		if (in_valid && in_ready)
			dec_op <= nxt_op;
	end

endmodule

// ==== rtl/rob_pkg.sv ====
// reorder buffer entry, branch resolution and retire types
`include "stomp_defines.svh"

package rob_pkg;

	// index of an entry in the reorder buffer
	typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

	// ========================================
	// storage
	// ========================================

	// taken holds the prediction until the branch resolves, then the outcome
	typedef struct packed {
		logic                  valid;
		logic                  stomped;
		logic [`SN_W-1:0]      sn;
		logic [`PC_W-1:0]      pc;
		logic [`STREAM_W-1:0]  stream;
		logic                  is_br;
		logic                  taken;
		logic [`PC_W-1:0]      result;
	} rob_entry_t;

	// ========================================
	// messages
	// ========================================

	// kept_stream is the stream that survives the branch
	// miss flips the stored prediction into the real outcome
	typedef struct packed {
		rob_tag_t              tag;
		logic [`STREAM_W-1:0]  kept_stream;
		logic                  miss;
	} resolve_t;

	typedef struct packed {
		logic [`PC_W-1:0]      pc;
		logic [`STREAM_W-1:0]  stream;
		logic                  is_br;
		logic                  taken;
		logic [`PC_W-1:0]      result;
	} retire_t;

endpackage

// ==== rtl/insn_pkg.sv ====
// instruction word views, fetch packet and decoded operation types
`include "stomp_defines.svh"

package insn_pkg;

	// ========================================
	// instruction word
	// ========================================

	typedef enum logic [3:0] {
		OP_ALU = 4'd0,
		OP_BR  = 4'd1
	} opcode_e;

	// ALU form produces pc plus a sign-free 16 bit immediate
	typedef struct packed {
		opcode_e            opcode;
		logic [11:0]        pad;
		logic [`IMM_W-1:0]  imm;
	} alu_fmt_t;

	// branch form is taken when the two compare fields are equal
	typedef struct packed {
		opcode_e               opcode;
		logic [`STREAM_W-1:0]  target_stream;
		logic [3:0]            cmp_a;
		logic [3:0]            cmp_b;
		logic [16:0]           target_off;
	} br_fmt_t;

	// the same 32 bits read either way, the opcode sits on top in both
	typedef union packed {
		alu_fmt_t  alu_fmt;
		br_fmt_t   br_fmt;
	} insn_word_u;

	// ========================================
	// pipeline payloads
	// ========================================

	typedef struct packed {
		logic [`PC_W-1:0]      pc;
		logic [`STREAM_W-1:0]  stream;
		logic                  pred_taken;
		insn_word_u            word;
	} fetch_pkt_t;

	typedef struct packed {
		logic [`PC_W-1:0]      pc;
		logic [`STREAM_W-1:0]  stream;
		logic                  pred_taken;
		logic                  is_br;
		logic [`IMM_W-1:0]     imm16;
		logic [`STREAM_W-1:0]  target_stream;
		logic [3:0]            cmp_a;
		logic [3:0]            cmp_b;
		logic [`PC_W-1:0]      target_pc;
	} dec_op_t;

endpackage

// ==== rtl/stomp_defines.svh ====
// width and depth constants shared by the branch recovery back end
`ifndef STOMP_DEFINES_SVH
`define STOMP_DEFINES_SVH

// program counter width, also the width of an ALU result
`define PC_W 16

// fetch stream identifier width
`define STREAM_W 3

// reorder buffer size, a power of two so the pointers wrap by themselves
`define ROB_DEPTH 8
`define ROB_TAG_W 3

// sequence numbers carry one bit more than the tag so age compares survive wrap
`define SN_W 4

// immediate field of the ALU form
`define IMM_W 16

`endif
